//--- flist.f
verilog/bridge_bus_pkg.sv
verilog/bridge_lane_pkg.sv
verilog/load_issue.sv
verilog/store_issue.sv
verilog/lane_complete.sv
verilog/mem_bridge.sv
verif/axi_mem_model.sv
verif/tb_mem_bridge.sv

//--- run_sim.sh
#!/bin/sh
# build and run the mem_bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_mem_bridge \
	-f flist.f \
	-o sim_mem_bridge

out=$(./obj_dir/sim_mem_bridge)
echo "$out"

# nonzero exit when the pass line is missing
echo "$out" | grep -q "^Everything OK$"

//--- verif/axi_mem_model.sv
`timescale 1ns/10ps

module axi_mem_model
	import bridge_bus_pkg::*;
#(
	parameter int          ADDR_W = 32,
	parameter logic [31:0] SEED   = 32'd1
)
(
	input  logic              clk,
	input  logic              arvalid,
	input  logic [ADDR_W-1:0] raddr,
	input  logic [ID_W-1:0]   raddr_id,
	input  logic              raddr_valid,
	output logic              raddr_ready,
	output logic [DATA_W-1:0] rdata,
	output logic [ID_W-1:0]   rid,
	output bus_resp_e         rresp,
	output logic              rvalid,
	input  logic              rready,
	input  logic [ADDR_W-1:0] waddr,
	input  logic [ID_W-1:0]   waddr_id,
	input  logic              waddr_valid,
	output logic              waddr_ready,
	input  logic [DATA_W-1:0] wdata,
	input  logic [STRB_W-1:0] wstrb,
	input  logic              wvalid,
	output logic              wready,
	output logic [ID_W-1:0]   bid,
	output bus_resp_e         bresp,
	output logic              bvalid,
	input  logic              bready
);

	// 256 words indexed by byte address bits 9:2
	logic [DATA_W-1:0] mem [0:255];
	logic [ID_W-1:0]   pend_id [$];
	logic [DATA_W-1:0] pend_data [$];
	integer            seed;
	logic [31:0]       rnd;
	int                k;
	logic              aw_got;
	logic              w_got;
	logic              b_pend;
	logic [7:0]        aw_idx;
	logic [ID_W-1:0]   aw_id;
	logic [DATA_W-1:0] w_data;
	logic [STRB_W-1:0] w_strb;
	logic [1:0]        b_wait;

	always @(posedge clk or posedge arvalid)
	begin
		if (arvalid)
		begin
			seed = SEED;
			// each word holds its own byte address above a tag
			for (int i = 0; i < 256; i++)
				mem[i] = 32'hc0de0000 + (32'(i) << 2);
			pend_id.delete();
			pend_data.delete();
			aw_got = 1'b0;
			w_got = 1'b0;
			b_pend = 1'b0;
			b_wait = 2'd0;
			raddr_ready <= 1'b0;
			rvalid <= 1'b0;
			rdata <= '0;
			rid <= '0;
			rresp <= OKAY;
			waddr_ready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			bid <= '0;
			bresp <= OKAY;
		end
		else
		begin
			rnd = $random(seed);
			raddr_ready <= rnd[0];
			waddr_ready <= rnd[1];
			wready <= rnd[2];

			////////////////////
			// read side
			////////////////////

			if (raddr_valid && raddr_ready)
			begin
				pend_id.push_back(raddr_id);
				pend_data.push_back(mem[raddr[9:2]]);
			end
			if (rvalid && rready)
				rvalid <= 1'b0;
			else if (!rvalid && pend_id.size() > 0 && rnd[4:3] == 2'b00)
			begin
				// younger read may overtake the older one
				k = (pend_id.size() > 1 && rnd[5]) ? 1 : 0;
				rvalid <= 1'b1;
				rdata <= pend_data[k];
				rid <= pend_id[k];
				rresp <= OKAY;
				pend_id.delete(k);
				pend_data.delete(k);
			end

			////////////////////
			// write side
			////////////////////

			if (waddr_valid && waddr_ready && !aw_got)
			begin
				aw_got = 1'b1;
				aw_idx = waddr[9:2];
				aw_id = waddr_id;
			end
			if (wvalid && wready && !w_got)
			begin
				w_got = 1'b1;
				w_data = wdata;
				w_strb = wstrb;
			end
			if (aw_got && w_got)
			begin
				for (int b = 0; b < STRB_W; b++)
					if (w_strb[b])
						mem[aw_idx][b*8 +: 8] = w_data[b*8 +: 8];
				aw_got = 1'b0;
				w_got = 1'b0;
				b_pend = 1'b1;
				b_wait = rnd[7:6];
			end
			if (bvalid && bready)
				bvalid <= 1'b0;
			else if (b_pend && !bvalid)
			begin
				if (b_wait == 2'd0)
				begin
					bvalid <= 1'b1;
					bid <= aw_id;
					bresp <= OKAY;
					b_pend = 1'b0;
				end
				else
					b_wait = b_wait - 2'd1;
			end
		end
	end

endmodule

//--- verif/mem_bridge_trace.txt
# op1 size1 addr1 wdata1 exp1 op2 size2 addr2 wdata2 exp2, all hex
# op 0 load 1 store, size 0 byte 1 half 2 word, exp is rdata for loads and wstrb for stores
1 2 00000100 11223344 0000000f 1 2 00000104 55667788 0000000f
0 2 00000100 00000000 11223344 0 2 00000104 00000000 55667788
1 0 00000101 0000ab00 00000002 1 1 00000106 cdef0000 0000000c
0 2 00000100 00000000 1122ab44 0 2 00000104 00000000 cdef7788
0 0 00000101 00000000 000000ab 0 1 00000106 00000000 0000cdef
0 0 00000103 00000000 00000011 0 1 00000104 00000000 00007788
1 2 00000200 deadbeef 0000000f 0 2 00000200 00000000 deadbeef
0 2 00000200 00000000 deadbeef 0 2 00000300 00000000 c0de0300
1 0 00000303 5a000000 00000008 1 1 00000300 00001234 00000003
0 2 00000300 00000000 5ade1234 0 0 00000302 00000000 000000de
0 1 00000302 00000000 00005ade 0 0 00000100 00000000 00000044
1 1 00000202 12340000 0000000c 0 2 00000200 00000000 1234beef
0 2 000003fc 00000000 c0de03fc 0 0 000003fd 00000000 00000003

//--- verif/tb_mem_bridge.sv
`timescale 1ns/10ps

module tb_mem_bridge
	import bridge_bus_pkg::*, bridge_lane_pkg::*;
;

	localparam logic [31:0] SEED = 32'h655d2b65;
	localparam int CLK_PERIOD = 40;
	localparam int IN_DELAY = 2;
	localparam int CYCLES_PER_TEST = 64;
	localparam int RESET_CYCLES = 10;
	localparam int MAX_TESTS = 64;

	logic              clk;
	logic              arvalid;
	logic              lane_1_req;
	lane_op_e          lane_1_op;
	access_size_e      lane_1_size;
	logic [31:0]       lane_1_addr;
	logic [DATA_W-1:0] lane_1_wdata;
	logic              lane_1_done;
	logic [DATA_W-1:0] lane_1_rdata;
	logic              lane_2_req;
	lane_op_e          lane_2_op;
	access_size_e      lane_2_size;
	logic [31:0]       lane_2_addr;
	logic [DATA_W-1:0] lane_2_wdata;
	logic              lane_2_done;
	logic [DATA_W-1:0] lane_2_rdata;
	logic [31:0]       raddr;
	logic [ID_W-1:0]   raddr_id;
	access_size_e      raddr_size;
	logic              raddr_valid;
	logic              raddr_ready;
	logic [DATA_W-1:0] rdata;
	logic [ID_W-1:0]   rid;
	bus_resp_e         rresp;
	logic              rvalid;
	logic              rready;
	logic [31:0]       waddr;
	logic [ID_W-1:0]   waddr_id;
	logic              waddr_valid;
	logic              waddr_ready;
	logic [DATA_W-1:0] wdata;
	logic [STRB_W-1:0] wstrb;
	logic              wvalid;
	logic              wready;
	logic [ID_W-1:0]   bid;
	bus_resp_e         bresp;
	logic              bvalid;
	logic              bready;

	// five trace columns per lane with lane 1 first
	logic [31:0] tv [0:MAX_TESTS-1][0:9];
	int          n_tests;
	int          errors;
	int          failed_tests;
	int          limit;
	int          cycles = 0;
	int          raddr_hits = 0;
	bit          bus_ok;
	logic [29:0] watch_word;
	logic [STRB_W-1:0] strb_1;
	logic [STRB_W-1:0] strb_2;
	logic [DATA_W-1:0] got_1;
	logic [DATA_W-1:0] got_2;

	mem_bridge UUT (.*);

	axi_mem_model #(.SEED(SEED)) u_mem (.*);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	////////////////////
	// bus monitors
	////////////////////

	always @(posedge clk)
	begin
		if (wvalid && wready)
		begin
			if (waddr_id == LANE1_ID)
				strb_1 <= wstrb;
			else
				strb_2 <= wstrb;
		end
		// read size follows the requesting lane
		if (raddr_valid && raddr_ready)
			check_value("raddr_size",
				32'(raddr_id == LANE1_ID ? lane_1_size : lane_2_size),
				32'(raddr_size), bus_ok);
		if (raddr_valid && raddr[31:2] == watch_word)
			raddr_hits <= raddr_hits + 1;
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit)
		begin
			$display("timeout after %0d cycles, lane done never arrived", cycles);
			$display("Something failed");
			$finish;
		end
	end

	task automatic load_trace;
		string line;
		int fd;
		int cnt;
		logic [31:0] v [0:9];
		n_tests = 0;
		fd = $fopen("verif/mem_bridge_trace.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open the trace file");
			errors++;
		end
		else
		begin
			while (!$feof(fd) && n_tests < MAX_TESTS)
			begin
				cnt = $fgets(line, fd);
				if (cnt > 1 && line[0] != "#")
				begin
					cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
						v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9]);
					if (cnt == 10)
					begin
						for (int j = 0; j < 10; j++)
							tv[n_tests][j] = v[j];
						n_tests++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] got, inout bit ok);
		assert (got === exp)
		else
		begin
			$display("MISMATCH %s expected %08h actual %08h", name, exp, got);
			ok = 1'b0;
			errors++;
		end
	endtask

	task automatic run_pair(input int t);
		bit ok;
		bit seen_1;
		bit seen_2;
		bit fwd;
		int hits_before;
		ok = 1'b1;
		seen_1 = 1'b0;
		seen_2 = 1'b0;
		// word store on lane 1 and word load of the same word on lane 2
		fwd = tv[t][0] == 1 && tv[t][5] == 0 && tv[t][1] == 2 && tv[t][6] == 2 &&
			tv[t][2][31:2] == tv[t][7][31:2];
		@(posedge clk);
		#IN_DELAY;
		watch_word = fwd ? tv[t][2][31:2] : '1;
		hits_before = raddr_hits;
		bus_ok = 1'b1;
		lane_1_op = lane_op_e'(tv[t][0][0]);
		lane_1_size = access_size_e'(tv[t][1][1:0]);
		lane_1_addr = tv[t][2];
		lane_1_wdata = tv[t][3];
		lane_2_op = lane_op_e'(tv[t][5][0]);
		lane_2_size = access_size_e'(tv[t][6][1:0]);
		lane_2_addr = tv[t][7];
		lane_2_wdata = tv[t][8];
		lane_1_req = 1'b1;
		lane_2_req = 1'b1;
		while (!(seen_1 && seen_2))
		begin
			@(posedge clk);
			#IN_DELAY;
			if (lane_1_done)
			begin
				seen_1 = 1'b1;
				got_1 = lane_1_rdata;
				lane_1_req = 1'b0;
			end
			if (lane_2_done)
			begin
				seen_2 = 1'b1;
				got_2 = lane_2_rdata;
				lane_2_req = 1'b0;
			end
		end
		if (tv[t][0] == 0)
			check_value("lane_1_rdata", tv[t][4], got_1, ok);
		else
			check_value("wstrb", tv[t][4], 32'(strb_1), ok);
		if (tv[t][5] == 0)
			check_value("lane_2_rdata", tv[t][9], got_2, ok);
		else
			check_value("wstrb", tv[t][9], 32'(strb_2), ok);
		if (fwd)
		begin
			assert (raddr_hits == hits_before)
			else
			begin
				$display("forwarded lane 2 load was also read over the bus");
				ok = 1'b0;
				errors++;
			end
		end
		if (!bus_ok)
			ok = 1'b0;
		if (!ok)
			failed_tests++;
		$display("test %0d %s", t + 1, ok ? "passed" : "failed");
	endtask

	initial
	begin : main
		bit ok;
		arvalid = 1'b1;
		lane_1_req = 1'b0;
		lane_1_op = OP_LOAD;
		lane_1_size = SIZE_BYTE;
		lane_1_addr = '0;
		lane_1_wdata = '0;
		lane_2_req = 1'b0;
		lane_2_op = OP_LOAD;
		lane_2_size = SIZE_BYTE;
		lane_2_addr = '0;
		lane_2_wdata = '0;
		watch_word = '1;
		bus_ok = 1'b1;
		errors = 0;
		failed_tests = 0;
		limit = 0;
		load_trace();
		limit = n_tests * CYCLES_PER_TEST + RESET_CYCLES + 4;
		repeat (RESET_CYCLES) @(posedge clk);
		#IN_DELAY;
		arvalid = 1'b0;

		// idle bus and lanes before any request
		@(posedge clk);
		#IN_DELAY;
		ok = 1'b1;
		check_value("raddr_valid", 32'd0, 32'(raddr_valid), ok);
		check_value("waddr_valid", 32'd0, 32'(waddr_valid), ok);
		check_value("wvalid", 32'd0, 32'(wvalid), ok);
		check_value("lane_1_done", 32'd0, 32'(lane_1_done), ok);
		check_value("lane_2_done", 32'd0, 32'(lane_2_done), ok);
		if (!ok)
			failed_tests++;
		$display("test 0 %s", ok ? "passed" : "failed");

		for (int t = 0; t < n_tests; t++)
			run_pair(t);

		$display("%0d tests run, %0d failed, %0d errors", n_tests + 1, failed_tests, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

//--- verilog/bridge_bus_pkg.sv
package bridge_bus_pkg;

	////////////////////
	// bus geometry
	////////////////////

	// one single-beat word per transfer, byte strobes per lane
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;

	// transaction id width on all channels
	localparam int ID_W = 4;

	////////////////////
	// lane tags
	////////////////////

	// every channel tags lane traffic with these ids
	localparam logic [ID_W-1:0] LANE1_ID = 4'd1;
	localparam logic [ID_W-1:0] LANE2_ID = 4'd2;

	// response codes on the read data and write response channels
	typedef enum logic [1:0]
	{
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} bus_resp_e;

endpackage

//--- verilog/bridge_lane_pkg.sv
package bridge_lane_pkg;

	////////////////////
	// lane request fields
	////////////////////

	// access size, same code as the bus size field
	typedef enum logic [1:0]
	{
		SIZE_BYTE = 2'd0,
		SIZE_HALF = 2'd1,
		SIZE_WORD = 2'd2
	} access_size_e;

	typedef enum logic
	{
		OP_LOAD  = 1'b0,
		OP_STORE = 1'b1
	} lane_op_e;

	////////////////////
	// engine states
	////////////////////

	// read address channel
	typedef enum logic {LD_IDLE, LD_ADDR} load_state_e;

	// write address/data, then write response
	typedef enum logic [1:0] {ST_IDLE, ST_SEND, ST_RESP} store_state_e;

endpackage

//--- verilog/lane_complete.sv
`timescale 1ns/10ps

module lane_complete
	import bridge_bus_pkg::*, bridge_lane_pkg::*;
#(
	parameter int ADDR_W = 32
)
(
	input  logic              clk,
	input  logic              arvalid,
	input  access_size_e      lane_1_size,
	input  access_size_e      lane_2_size,
	input  logic [ADDR_W-1:0] lane_1_addr,
	input  logic [ADDR_W-1:0] lane_2_addr,
	input  logic [DATA_W-1:0] lane_1_wdata,
	input  logic              ld_ret_valid,
	input  logic              ld_ret_lane2,
	input  logic [DATA_W-1:0] ld_ret_data,
	input  logic              fwd_lane2,
	input  logic              st_done_1,
	input  logic              st_done_2,
	output logic              lane_1_done,
	output logic              lane_2_done,
	output logic [DATA_W-1:0] lane_1_rdata,
	output logic [DATA_W-1:0] lane_2_rdata
);

	logic ret_1;
	logic ret_2;
	logic fwd_hit;

	// addressed bytes moved to bit 0, zero filled above
	function automatic logic [DATA_W-1:0] extract(input logic [DATA_W-1:0] word,
		input access_size_e size, input logic [1:0] ofs);
		logic [DATA_W-1:0] shifted;
		shifted = word >> {ofs, 3'b000};
		case (size)
			SIZE_BYTE: return DATA_W'(shifted[7:0]);
			SIZE_HALF: return DATA_W'(shifted[15:0]);
			default:   return shifted;
		endcase
	endfunction

	assign ret_1 = ld_ret_valid && !ld_ret_lane2;
	assign ret_2 = ld_ret_valid && ld_ret_lane2;

	// forwarded load finishes behind the store it copies
	assign fwd_hit = fwd_lane2 && lane_1_done;

	////////////////////
	// done pulses
	////////////////////

	always_ff @(posedge clk or posedge arvalid)
	begin
		if (arvalid)
		begin
			lane_1_done <= 1'b0;
			lane_2_done <= 1'b0;
		end
		else
		begin
			lane_1_done <= st_done_1 || ret_1;
			lane_2_done <= st_done_2 || ret_2 || fwd_hit;
		end
	end

	////////////////////
	// load data
	////////////////////

	always_ff @(posedge clk)
	begin
		if (ret_1)
			lane_1_rdata <= extract(ld_ret_data, lane_1_size, lane_1_addr[1:0]);
		if (fwd_hit)
			lane_2_rdata <= extract(lane_1_wdata, lane_2_size, lane_2_addr[1:0]);
		else if (ret_2)
			lane_2_rdata <= extract(ld_ret_data, lane_2_size, lane_2_addr[1:0]);
	end

endmodule

//--- verilog/load_issue.sv
`timescale 1ns/10ps

module load_issue
	import bridge_bus_pkg::*, bridge_lane_pkg::*;
#(
	parameter int ADDR_W = 32
)
(
	input  logic              clk,
	input  logic              arvalid,
	input  logic              lane_1_req,
	input  lane_op_e          lane_1_op,
	input  access_size_e      lane_1_size,
	input  logic [ADDR_W-1:0] lane_1_addr,
	input  logic              lane_2_req,
	input  lane_op_e          lane_2_op,
	input  access_size_e      lane_2_size,
	input  logic [ADDR_W-1:0] lane_2_addr,
	input  logic              lane_1_done,
	input  logic              lane_2_done,
	input  logic              raddr_ready,
	input  logic [DATA_W-1:0] rdata,
	input  logic [ID_W-1:0]   rid,
	input  bus_resp_e         rresp,
	input  logic              rvalid,
	output logic [ADDR_W-1:0] raddr,
	output logic [ID_W-1:0]   raddr_id,
	output access_size_e      raddr_size,
	output logic              raddr_valid,
	output logic              rready,
	output logic              ld_ret_valid,
	output logic              ld_ret_lane2,
	output logic [DATA_W-1:0] ld_ret_data,
	output logic              fwd_lane2
);

	load_state_e state;
	logic issued_1;
	logic issued_2;
	logic same_word;
	logic hazard;
	logic want_1;
	logic want_2;
	logic grant_1;
	logic grant_2;
	logic take_fwd;

	////////////////////
	// request decode
	////////////////////

	// lane 2 against a lane-1 store still in progress
	assign same_word = (lane_1_addr >> 2) == (lane_2_addr >> 2);
	assign hazard = lane_1_req && lane_1_op == OP_STORE && !lane_1_done && same_word;

	assign want_1 = lane_1_req && lane_1_op == OP_LOAD && !issued_1 && !lane_1_done;
	assign want_2 = lane_2_req && lane_2_op == OP_LOAD && !issued_2 && !fwd_lane2 && !lane_2_done;

	// lane 1 first, lane 2 waits out a store to its word
	assign grant_1 = state == LD_IDLE && want_1;
	assign grant_2 = state == LD_IDLE && want_2 && !want_1 && !hazard;

	// word over word can take the store data directly
	assign take_fwd = want_2 && hazard && lane_1_size == SIZE_WORD && lane_2_size == SIZE_WORD;

	always_ff @(posedge clk or posedge arvalid)
	begin
		if (arvalid)
		begin
			state <= LD_IDLE;
			raddr_valid <= 1'b0;
			issued_1 <= 1'b0;
			issued_2 <= 1'b0;
			fwd_lane2 <= 1'b0;
			rready <= 1'b0;
		end
		else
		begin
			rready <= 1'b1;
			if (grant_1 || grant_2)
			begin
				state <= LD_ADDR;
				raddr_valid <= 1'b1;
			end
			else if (state == LD_ADDR && raddr_ready)
			begin
				state <= LD_IDLE;
				raddr_valid <= 1'b0;
			end
			// in flight until the lane reports done
			if (grant_1)
				issued_1 <= 1'b1;
			else if (lane_1_done)
				issued_1 <= 1'b0;
			if (grant_2)
				issued_2 <= 1'b1;
			else if (lane_2_done)
				issued_2 <= 1'b0;
			if (take_fwd)
				fwd_lane2 <= 1'b1;
			else if (lane_2_done)
				fwd_lane2 <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (grant_1)
		begin
			raddr <= lane_1_addr;
			raddr_id <= LANE1_ID;
			raddr_size <= lane_1_size;
		end
		else if (grant_2)
		begin
			raddr <= lane_2_addr;
			raddr_id <= LANE2_ID;
			raddr_size <= lane_2_size;
		end
	end

	////////////////////
	// read return, steered by rid
	////////////////////

	assign ld_ret_valid = rvalid && rready &&
		((rid == LANE1_ID && issued_1) || (rid == LANE2_ID && issued_2));
	assign ld_ret_lane2 = rid == LANE2_ID;

	// error reads come back as zero
	assign ld_ret_data = (rresp == OKAY || rresp == EXOKAY) ? rdata : '0;

endmodule

//--- verilog/mem_bridge.sv
`timescale 1ns/10ps

module mem_bridge
	import bridge_bus_pkg::*, bridge_lane_pkg::*;
#(
	parameter int ADDR_W = 32
)
(
	input  logic              clk,
	input  logic              arvalid,
	// lane 1
	input  logic              lane_1_req,
	input  lane_op_e          lane_1_op,
	input  access_size_e      lane_1_size,
	input  logic [ADDR_W-1:0] lane_1_addr,
	input  logic [DATA_W-1:0] lane_1_wdata,
	output logic              lane_1_done,
	output logic [DATA_W-1:0] lane_1_rdata,
	// lane 2
	input  logic              lane_2_req,
	input  lane_op_e          lane_2_op,
	input  access_size_e      lane_2_size,
	input  logic [ADDR_W-1:0] lane_2_addr,
	input  logic [DATA_W-1:0] lane_2_wdata,
	output logic              lane_2_done,
	output logic [DATA_W-1:0] lane_2_rdata,
	// read address
	output logic [ADDR_W-1:0] raddr,
	output logic [ID_W-1:0]   raddr_id,
	output access_size_e      raddr_size,
	output logic              raddr_valid,
	input  logic              raddr_ready,
	// read data
	input  logic [DATA_W-1:0] rdata,
	input  logic [ID_W-1:0]   rid,
	input  bus_resp_e         rresp,
	input  logic              rvalid,
	output logic              rready,
	// write address
	output logic [ADDR_W-1:0] waddr,
	output logic [ID_W-1:0]   waddr_id,
	output logic              waddr_valid,
	input  logic              waddr_ready,
	// write data
	output logic [DATA_W-1:0] wdata,
	output logic [STRB_W-1:0] wstrb,
	output logic              wvalid,
	input  logic              wready,
	// write response
	input  logic [ID_W-1:0]   bid,
	input  bus_resp_e         bresp,
	input  logic              bvalid,
	output logic              bready
);

	// load side results
	logic              ld_ret_valid;
	logic              ld_ret_lane2;
	logic [DATA_W-1:0] ld_ret_data;
	logic              fwd_lane2;

	// store side results
	logic              st_done_1;
	logic              st_done_2;

	load_issue #(.ADDR_W(ADDR_W)) u_load_issue (.*);

	store_issue #(.ADDR_W(ADDR_W)) u_store_issue (.*);

	lane_complete #(.ADDR_W(ADDR_W)) u_lane_complete (.*);

endmodule

//--- verilog/store_issue.sv
`timescale 1ns/10ps

module store_issue
	import bridge_bus_pkg::*, bridge_lane_pkg::*;
#(
	parameter int ADDR_W = 32
)
(
	input  logic              clk,
	input  logic              arvalid,
	input  logic              lane_1_req,
	input  lane_op_e          lane_1_op,
	input  access_size_e      lane_1_size,
	input  logic [ADDR_W-1:0] lane_1_addr,
	input  logic [DATA_W-1:0] lane_1_wdata,
	input  logic              lane_2_req,
	input  lane_op_e          lane_2_op,
	input  access_size_e      lane_2_size,
	input  logic [ADDR_W-1:0] lane_2_addr,
	input  logic [DATA_W-1:0] lane_2_wdata,
	input  logic              lane_1_done,
	input  logic              lane_2_done,
	input  logic              waddr_ready,
	input  logic              wready,
	input  logic [ID_W-1:0]   bid,
	input  bus_resp_e         bresp,
	input  logic              bvalid,
	output logic [ADDR_W-1:0] waddr,
	output logic [ID_W-1:0]   waddr_id,
	output logic              waddr_valid,
	output logic [DATA_W-1:0] wdata,
	output logic [STRB_W-1:0] wstrb,
	output logic              wvalid,
	output logic              bready,
	output logic              st_done_1,
	output logic              st_done_2
);

	store_state_e state;
	logic issued_1;
	logic issued_2;
	logic grant_1;
	logic grant_2;
	logic aw_left;
	logic w_left;
	logic b_seen;
	logic b_ok;

	// byte lanes touched by one access
	function automatic logic [STRB_W-1:0] make_strb(input access_size_e size,
		input logic [1:0] ofs);
		case (size)
			SIZE_BYTE: return STRB_W'(1) << ofs;
			SIZE_HALF: return ofs[1] ? STRB_W'(4'b1100) : STRB_W'(4'b0011);
			default:   return '1;
		endcase
	endfunction

	assign grant_1 = state == ST_IDLE && lane_1_req && lane_1_op == OP_STORE &&
		!issued_1 && !lane_1_done;
	assign grant_2 = state == ST_IDLE && !grant_1 && lane_2_req && lane_2_op == OP_STORE &&
		!issued_2 && !lane_2_done;

	// channels still waiting after this edge
	assign aw_left = waddr_valid && !waddr_ready;
	assign w_left = wvalid && !wready;

	assign b_seen = state == ST_RESP && bvalid && bready;
	assign b_ok = bresp == OKAY || bresp == EXOKAY;

	always_ff @(posedge clk or posedge arvalid)
	begin
		if (arvalid)
		begin
			state <= ST_IDLE;
			waddr_valid <= 1'b0;
			wvalid <= 1'b0;
			issued_1 <= 1'b0;
			issued_2 <= 1'b0;
			bready <= 1'b0;
		end
		else
		begin
			bready <= 1'b1;
			case (state)
				ST_IDLE:
				begin
					if (grant_1 || grant_2)
					begin
						state <= ST_SEND;
						waddr_valid <= 1'b1;
						wvalid <= 1'b1;
					end
				end
				ST_SEND:
				begin
					// address and data drop independently
					if (waddr_ready)
						waddr_valid <= 1'b0;
					if (wready)
						wvalid <= 1'b0;
					if (!aw_left && !w_left)
						state <= ST_RESP;
				end
				default:
				begin
					if (b_seen && b_ok)
						state <= ST_IDLE;
					else if (b_seen)
					begin
						// error response, send the same beat again
						state <= ST_SEND;
						waddr_valid <= 1'b1;
						wvalid <= 1'b1;
					end
				end
			endcase
			if (grant_1)
				issued_1 <= 1'b1;
			else if (lane_1_done)
				issued_1 <= 1'b0;
			if (grant_2)
				issued_2 <= 1'b1;
			else if (lane_2_done)
				issued_2 <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (grant_1)
		begin
			waddr <= lane_1_addr;
			waddr_id <= LANE1_ID;
			wdata <= lane_1_wdata;
			wstrb <= make_strb(lane_1_size, lane_1_addr[1:0]);
		end
		else if (grant_2)
		begin
			waddr <= lane_2_addr;
			waddr_id <= LANE2_ID;
			wdata <= lane_2_wdata;
			wstrb <= make_strb(lane_2_size, lane_2_addr[1:0]);
		end
	end

	// response goes back to its lane by bid
	assign st_done_1 = b_seen && b_ok && bid == LANE1_ID;
	assign st_done_2 = b_seen && b_ok && bid == LANE2_ID;

endmodule
